// File: rtl/lpe_pkg.sv
package lpe_pkg;

  // Operand and accumulator widths
  localparam int OPERAND_W = 16;
  localparam int ACC_W     = 40;

  // Signed operand carried on the left and top streams
  typedef logic signed [OPERAND_W-1:0] operand_t;

  // Signed running sum, wraps modulo 2**ACC_W
  typedef logic signed [ACC_W-1:0] acc_t;

  // One beat of an operand stream
  typedef struct packed {
    operand_t data;
    logic     last;
  } op_beat_t;

  // Datapath control from the pairing FSM
  typedef struct packed {
    // Add the product of the current pair
    logic mac_en;
    // Load zero into the accumulator
    logic acc_clear;
  } lpe_ctrl_t;

  // Pairing FSM states
  typedef enum logic [2:0] {
    // Waiting for the first pair of a batch
    IDLE   = 3'd0,
    // Left operand held, waiting for top
    HOLD_L = 3'd1,
    // Top operand held, waiting for left
    HOLD_T = 3'd2,
    // Inside a batch, accumulating
    MAC    = 3'd3,
    // Result presented on the down port
    END    = 3'd4,
    // Misaligned last flags, batch discarded
    ERR    = 3'd5
  } lpe_state_e;

endpackage

// File: rtl/lpe_operand_hold.sv
`timescale 1ns/1ps

module lpe_operand_hold (
  input  logic             clk,
  input  logic             rst,
  input  logic             in_valid,
  input  lpe_pkg::op_beat_t in_beat,
  input  logic             accept,
  input  logic             keep,
  input  logic             release_beat,
  output logic             present,
  output lpe_pkg::op_beat_t out_beat
);
  import lpe_pkg::*;

  op_beat_t held_q;
  logic     full_q;

  // A held beat wins over the incoming one
  assign present  = full_q | (in_valid & accept);
  assign out_beat = full_q ? held_q : in_beat;

  always_ff @(posedge clk) begin
    if (rst) begin
      full_q <= 1'b0;
    end else if (release_beat) begin
      full_q <= 1'b0;
    end else if (keep) begin
      full_q <= 1'b1;
    end
  end

  // Beat storage
  always_ff @(posedge clk) begin
    if (keep) begin
      held_q <= out_beat;
    end
  end

endmodule

// File: rtl/lpe_mac_datapath.sv
`timescale 1ns/1ps

module lpe_mac_datapath (
  input  logic               clk,
  input  logic               rst,
  input  lpe_pkg::lpe_ctrl_t ctrl,
  input  lpe_pkg::operand_t  l_operand,
  input  lpe_pkg::operand_t  t_operand,
  output lpe_pkg::acc_t      sum
);
  import lpe_pkg::*;

  localparam int PROD_W = 2 * OPERAND_W;

  logic signed [PROD_W-1:0] product;
  acc_t                     product_ext;
  acc_t                     acc_q;

  // Full precision signed product
  assign product = PROD_W'(l_operand) * PROD_W'(t_operand);

  // Sign extend to the accumulator width
  assign product_ext = acc_t'(product);

  always_ff @(posedge clk) begin
    if (rst) begin
      acc_q <= '0;
    end else if (ctrl.acc_clear) begin
      acc_q <= '0;
    end else if (ctrl.mac_en) begin
      // Wraps on overflow
      acc_q <= acc_q + product_ext;
    end
  end

  assign sum = acc_q;

endmodule

// File: rtl/lpe_control_fsm.sv
`timescale 1ns/1ps

module lpe_control_fsm (
  input  logic               clk,
  input  logic               rst,
  input  logic               l_present,
  input  logic               t_present,
  input  logic               l_last,
  input  logic               t_last,
  input  logic               d_ready,
  output logic               l_accept,
  output logic               t_accept,
  output logic               l_keep,
  output logic               t_keep,
  output logic               l_release,
  output logic               t_release,
  output lpe_pkg::lpe_ctrl_t ctrl,
  output logic               d_valid,
  output logic               err_unaligned
);
  import lpe_pkg::*;

  lpe_state_e state_q;
  lpe_state_e state_d;

  logic open_both;
  logic pairing;
  logic pair;
  logic pair_end;
  logic pair_err;

  // Both streams open in IDLE and MAC
  assign open_both = (state_q == IDLE) || (state_q == MAC);

  // States in which a pair may form
  assign pairing = open_both || (state_q == HOLD_L) || (state_q == HOLD_T);

  assign pair     = pairing & l_present & t_present;
  assign pair_end = pair & l_last & t_last;
  assign pair_err = pair & (l_last ^ t_last);

  // A held side refuses its own stream
  assign l_accept = open_both || (state_q == HOLD_T);
  assign t_accept = open_both || (state_q == HOLD_L);

  // Lone operand is kept until its partner shows up
  assign l_keep = open_both & l_present & ~t_present;
  assign t_keep = open_both & t_present & ~l_present;

  // Every pair empties both holds, ERR flushes whatever is left
  assign l_release = pair || (state_q == ERR);
  assign t_release = pair || (state_q == ERR);

  // Misaligned pair is consumed without accumulating
  assign ctrl.mac_en    = pair & ~pair_err;
  assign ctrl.acc_clear = ((state_q == END) & d_ready) || (state_q == ERR);

  assign d_valid       = (state_q == END);
  assign err_unaligned = (state_q == ERR);

  always_comb begin
    state_d = state_q;
    case (state_q)
      IDLE, MAC: begin
        if (pair_end) begin
          state_d = END;
        end else if (pair_err) begin
          state_d = ERR;
        end else if (pair) begin
          state_d = MAC;
        end else if (l_present) begin
          state_d = HOLD_L;
        end else if (t_present) begin
          state_d = HOLD_T;
        end
      end
      HOLD_L, HOLD_T: begin
        if (pair_end) begin
          state_d = END;
        end else if (pair_err) begin
          state_d = ERR;
        end else if (pair) begin
          state_d = MAC;
        end
      end
      END: begin
        // Result waits for the down handshake
        if (d_ready) begin
          state_d = IDLE;
        end
      end
      ERR: begin
        state_d = IDLE;
      end
      default: begin
        state_d = IDLE;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state_q <= IDLE;
    end else begin
      state_q <= state_d;
    end
  end

endmodule

// File: rtl/lpe_top.sv
`timescale 1ns/1ps

module lpe_top (
  input  logic              clk,
  input  logic              rst,
  // Left operand stream
  input  logic              l_valid,
  input  lpe_pkg::op_beat_t l_beat,
  output logic              l_ready,
  // Top operand stream
  input  logic              t_valid,
  input  lpe_pkg::op_beat_t t_beat,
  output logic              t_ready,
  // Down result
  output logic              d_valid,
  output lpe_pkg::acc_t     d_sum,
  input  logic              d_ready,
  output logic              err_unaligned
);
  import lpe_pkg::*;

  logic      l_present;
  logic      t_present;
  logic      l_accept;
  logic      t_accept;
  logic      l_keep;
  logic      t_keep;
  logic      l_release;
  logic      t_release;
  op_beat_t  l_op;
  op_beat_t  t_op;
  lpe_ctrl_t ctrl;

  assign l_ready = l_accept;
  assign t_ready = t_accept;

  lpe_operand_hold u_hold_l (
    .clk          (clk),
    .rst          (rst),
    .in_valid     (l_valid),
    .in_beat      (l_beat),
    .accept       (l_accept),
    .keep         (l_keep),
    .release_beat (l_release),
    .present      (l_present),
    .out_beat     (l_op)
  );

  lpe_operand_hold u_hold_t (
    .clk          (clk),
    .rst          (rst),
    .in_valid     (t_valid),
    .in_beat      (t_beat),
    .accept       (t_accept),
    .keep         (t_keep),
    .release_beat (t_release),
    .present      (t_present),
    .out_beat     (t_op)
  );

  // Pairing control sees only the last flags
  lpe_control_fsm u_fsm (
    .clk           (clk),
    .rst           (rst),
    .l_present     (l_present),
    .t_present     (t_present),
    .l_last        (l_op.last),
    .t_last        (t_op.last),
    .d_ready       (d_ready),
    .l_accept      (l_accept),
    .t_accept      (t_accept),
    .l_keep        (l_keep),
    .t_keep        (t_keep),
    .l_release     (l_release),
    .t_release     (t_release),
    .ctrl          (ctrl),
    .d_valid       (d_valid),
    .err_unaligned (err_unaligned)
  );

  lpe_mac_datapath u_datapath (
    .clk       (clk),
    .rst       (rst),
    .ctrl      (ctrl),
    .l_operand (l_op.data),
    .t_operand (t_op.data),
    .sum       (d_sum)
  );

endmodule

// File: sim/lpe_props.sv
`timescale 1ns/1ps

module lpe_props (
  input logic          clk,
  input logic          rst,
  input logic          l_ready,
  input logic          t_ready,
  input logic          d_valid,
  input logic          d_ready,
  input logic          err_unaligned,
  input lpe_pkg::acc_t d_sum
);

  // Result held until the sink takes it
  sum_stable: assert property (@(posedge clk) disable iff (rst)
    d_valid && !d_ready |=> $stable(d_sum))
    else $error("d_sum changed while waiting for d_ready");

  // No new operands while a result waits
  ready_closed: assert property (@(posedge clk) disable iff (rst)
    d_valid |-> !l_ready && !t_ready)
    else $error("operand ready high while d_valid is high");

  err_one_cycle: assert property (@(posedge clk) disable iff (rst)
    err_unaligned |=> !err_unaligned)
    else $error("err_unaligned high for two cycles");

endmodule

bind lpe_top lpe_props u_props (
  .clk           (clk),
  .rst           (rst),
  .l_ready       (l_ready),
  .t_ready       (t_ready),
  .d_valid       (d_valid),
  .d_ready       (d_ready),
  .err_unaligned (err_unaligned),
  .d_sum         (d_sum)
);

// File: sim/lpe_tb.sv
`timescale 1ns/1ps

module lpe_tb;
  import lpe_pkg::*;

  localparam int TIMEOUT = 200;

  logic     clk;
  logic     rst;
  logic     l_valid;
  op_beat_t l_beat;
  logic     l_ready;
  logic     t_valid;
  op_beat_t t_beat;
  logic     t_ready;
  logic     d_valid;
  acc_t     d_sum;
  logic     d_ready;
  logic     err_unaligned;

  // Current batch, one entry per pair
  op_beat_t    l_beats[$];
  op_beat_t    t_beats[$];
  int          l_gaps[$];
  int          t_gaps[$];
  logic [31:0] rand_state;

  lpe_top dut (
    .clk           (clk),
    .rst           (rst),
    .l_valid       (l_valid),
    .l_beat        (l_beat),
    .l_ready       (l_ready),
    .t_valid       (t_valid),
    .t_beat        (t_beat),
    .t_ready       (t_ready),
    .d_valid       (d_valid),
    .d_sum         (d_sum),
    .d_ready       (d_ready),
    .err_unaligned (err_unaligned)
  );

  always #5 clk = ~clk;

  task automatic stop_with_failure(input string reason);
    $display("%s", reason);
    $display("*** TEST FAILED ***");
    $fatal(1, "Simulation stopped on error");
  endtask

  task automatic check(input string name, input logic [63:0] got, input logic [63:0] exp);
    if (got !== exp) begin
      stop_with_failure($sformatf("Fail: %s got 0x%h expected 0x%h", name, got, exp));
    end
  endtask

  function automatic logic [31:0] next_rand();
    rand_state = rand_state * 32'd1664525 + 32'd1013904223;
    return rand_state;
  endfunction

  // Upper LCG bits are the better ones
  function automatic int rand_below(input int n);
    return int'((next_rand() >> 16) % n);
  endfunction

  // Sum of all pair products, wrapped to the accumulator width
  function automatic acc_t model_sum();
    longint   total;
    operand_t a;
    operand_t b;
    total = 0;
    foreach (l_beats[i]) begin
      a = l_beats[i].data;
      b = t_beats[i].data;
      total += longint'(a) * longint'(b);
    end
    return acc_t'(total);
  endfunction

  task automatic new_batch();
    l_beats.delete();
    t_beats.delete();
    l_gaps.delete();
    t_gaps.delete();
  endtask

  task automatic add_pair(input operand_t l, input operand_t t, input logic l_last,
                          input logic t_last, input int l_gap, input int t_gap);
    l_beats.push_back(op_beat_t'{data: l, last: l_last});
    t_beats.push_back(op_beat_t'{data: t, last: t_last});
    l_gaps.push_back(l_gap);
    t_gaps.push_back(t_gap);
  endtask

  // Sends one side of the batch, gap cycles before each beat
  task automatic send_stream(input bit top);
    int n;
    int cnt;
    bit rdy;
    n = top ? t_beats.size() : l_beats.size();
    for (int i = 0; i < n; i++) begin
      repeat (top ? t_gaps[i] : l_gaps[i]) begin
        @(posedge clk);
        #1;
      end
      if (top) begin
        t_valid = 1'b1;
        t_beat  = t_beats[i];
      end else begin
        l_valid = 1'b1;
        l_beat  = l_beats[i];
      end
      cnt = 0;
      rdy = 1'b0;
      while (!rdy) begin
        @(negedge clk);
        rdy = top ? t_ready : l_ready;
        cnt++;
        if (!rdy && cnt > TIMEOUT) begin
          stop_with_failure("Timed out waiting for an operand ready");
        end
      end
      @(posedge clk);
      #1;
      if (top) t_valid = 1'b0;
      else l_valid = 1'b0;
    end
  endtask

  task automatic run_batch();
    fork
      send_stream(1'b0);
      send_stream(1'b1);
    join
  endtask

  task automatic wait_for_result();
    int cnt;
    cnt = 0;
    @(negedge clk);
    while (!d_valid) begin
      cnt++;
      if (cnt > TIMEOUT) begin
        stop_with_failure("Timed out waiting for a result on the down port");
      end
      @(negedge clk);
    end
  endtask

  // Down handshake, then both readies must be open again
  task automatic finish_result();
    @(posedge clk);
    #1 d_ready = 1'b1;
    @(posedge clk);
    #1 d_ready = 1'b0;
    @(negedge clk);
    check("d_valid", 64'(d_valid), 64'd0);
    check("l_ready", 64'(l_ready), 64'd1);
    check("t_ready", 64'(t_ready), 64'd1);
    @(posedge clk);
    #1;
  endtask

  task automatic receive_result();
    wait_for_result();
    check("d_sum", 64'(d_sum), 64'(model_sum()));
    finish_result();
  endtask

  task automatic test_reset();
    @(negedge clk);
    check("l_ready", 64'(l_ready), 64'd1);
    check("t_ready", 64'(t_ready), 64'd1);
    check("d_valid", 64'(d_valid), 64'd0);
    check("err_unaligned", 64'(err_unaligned), 64'd0);
    @(posedge clk);
    #1;
  endtask

  task automatic test_aligned();
    new_batch();
    add_pair(16'sd3, 16'sd7, 1'b0, 1'b0, 0, 0);
    add_pair(-16'sd12, 16'sd5, 1'b0, 1'b0, 0, 0);
    add_pair(16'sd100, -16'sd200, 1'b0, 1'b0, 0, 0);
    add_pair(16'sd32767, 16'sd32767, 1'b1, 1'b1, 0, 0);
    run_batch();
    receive_result();
  endtask

  // Lone side must stay closed while its partner is late
  task automatic watch_lone_ready(input bit top_first);
    @(negedge clk);
    repeat (5) begin
      @(negedge clk);
      check(top_first ? "t_ready" : "l_ready", 64'(top_first ? t_ready : l_ready), 64'd0);
      check(top_first ? "l_ready" : "t_ready", 64'(top_first ? l_ready : t_ready), 64'd1);
    end
  endtask

  task automatic test_stagger(input bit top_first);
    new_batch();
    add_pair(-16'sd9, 16'sd41, 1'b0, 1'b0, top_first ? 6 : 0, top_first ? 0 : 6);
    add_pair(16'sd250, -16'sd3, 1'b1, 1'b1, 0, 0);
    fork
      send_stream(1'b0);
      send_stream(1'b1);
      watch_lone_ready(top_first);
    join
    receive_result();
  endtask

  task automatic test_backpressure();
    acc_t held;
    new_batch();
    add_pair(16'sd1000, 16'sd1000, 1'b0, 1'b0, 0, 1);
    add_pair(-16'sd77, 16'sd12, 1'b0, 1'b0, 2, 0);
    add_pair(16'sd5, 16'sd6, 1'b1, 1'b1, 0, 0);
    run_batch();
    wait_for_result();
    held = d_sum;
    check("d_sum", 64'(held), 64'(model_sum()));
    repeat (6) begin
      @(negedge clk);
      check("d_valid", 64'(d_valid), 64'd1);
      check("d_sum", 64'(d_sum), 64'(held));
      check("l_ready", 64'(l_ready), 64'd0);
      check("t_ready", 64'(t_ready), 64'd0);
    end
    finish_result();
    // Next batch must not see the old sum
    new_batch();
    add_pair(16'sd2, 16'sd3, 1'b1, 1'b1, 0, 0);
    run_batch();
    receive_result();
  endtask

  task automatic test_misaligned();
    int cnt;
    new_batch();
    add_pair(16'sd40, 16'sd50, 1'b0, 1'b0, 0, 0);
    add_pair(16'sd8, 16'sd9, 1'b1, 1'b0, 0, 0);
    run_batch();
    cnt = 0;
    @(negedge clk);
    while (!err_unaligned) begin
      cnt++;
      if (cnt > TIMEOUT) begin
        stop_with_failure("Timed out waiting for the unaligned data error");
      end
      @(negedge clk);
    end
    check("d_valid", 64'(d_valid), 64'd0);
    check("l_ready", 64'(l_ready), 64'd0);
    check("t_ready", 64'(t_ready), 64'd0);
    @(negedge clk);
    check("err_unaligned", 64'(err_unaligned), 64'd0);
    check("d_valid", 64'(d_valid), 64'd0);
    @(posedge clk);
    #1;
    new_batch();
    add_pair(-16'sd4, 16'sd11, 1'b0, 1'b0, 0, 0);
    add_pair(16'sd6, 16'sd6, 1'b1, 1'b1, 0, 0);
    run_batch();
    receive_result();
  endtask

  task automatic test_random(input int count);
    int len;
    for (int b = 0; b < count; b++) begin
      new_batch();
      len = 1 + rand_below(6);
      for (int i = 0; i < len; i++) begin
        add_pair(operand_t'(next_rand() >> 8), operand_t'(next_rand() >> 8),
                 i == len - 1, i == len - 1, rand_below(4), rand_below(4));
      end
      run_batch();
      receive_result();
    end
  endtask

  initial begin
    clk        = 1'b0;
    rst        = 1'b1;
    l_valid    = 1'b0;
    l_beat     = '0;
    t_valid    = 1'b0;
    t_beat     = '0;
    d_ready    = 1'b0;
    rand_state = 32'h5f1a_aca5;
    repeat (4) @(posedge clk);
    #1 rst = 1'b0;
    test_reset();
    test_aligned();
    test_stagger(1'b0);
    test_stagger(1'b1);
    test_backpressure();
    test_misaligned();
    test_random(12);
    $display("*** TEST PASSED ***");
    $finish;
  end

endmodule

// File: flist.f
rtl/lpe_pkg.sv
rtl/lpe_operand_hold.sv
rtl/lpe_mac_datapath.sv
rtl/lpe_control_fsm.sv
rtl/lpe_top.sv
sim/lpe_props.sv
sim/lpe_tb.sv

// File: run.sh
#!/usr/bin/env bash
# Build and run the processing element testbench with Verilator

cd "$(dirname "$0")" || exit 1

if ! command -v verilator > /dev/null 2>&1; then
  echo "verilator not found in PATH"
  exit 1
fi

verilator --binary --timing --assert --top-module lpe_tb \
  -f flist.f --Mdir obj_dir -o lpe_sim
status=$?
if [ $status -ne 0 ]; then
  echo "Build failed with status $status"
  exit $status
fi

./obj_dir/lpe_sim
status=$?
if [ $status -ne 0 ]; then
  echo "Simulation failed with status $status"
  exit $status
fi

exit 0
